// ==== logic/key_rx_pkg.sv ====
`default_nettype none

package key_rx_pkg;

  // width of one I or Q component.
  localparam int sample_width = 16;

  // accumulated power needs the squared width plus room for a long run.
  localparam int pow_width = 2 * sample_width + 10;

  // one complex baseband sample with i in the upper word.
  typedef struct packed {
    logic [sample_width-1:0] i;
    logic [sample_width-1:0] q;
  } sample_t;

  typedef logic [pow_width-1:0] pow_t;

  // report from the energy detector to the capture controller.
  typedef struct packed {
    logic       peak;           // one cycle strobe when the run reaches the trigger length.
    logic [15:0] nrx_after_peak; // samples in the run so far, trigger included.
    pow_t       pow;            // power summed over the run.
  } det_event_t;

  // capture controller states.
  typedef enum logic [1:0] {
    st_init,
    st_write,
    st_read,
    st_wait
  } ctrl_state_e;

endpackage

`default_nettype wire

// ==== logic/energy_detect.sv ====
`timescale 1ns/1ps
`default_nettype none

module energy_detect #(
  parameter int NRX_TRIG = 64
) (
  input  wire logic                  clk,
  input  wire logic                  reset,
  input  wire logic                  clear,
  input  wire logic                  enable,
  input  wire logic                  in_tvalid,
  input  wire logic                  in_tready,
  input  wire logic                  in_tlast,
  input  wire key_rx_pkg::sample_t   in_tdata,
  input  wire key_rx_pkg::sample_t   noise_thres,
  output key_rx_pkg::det_event_t     det_event
);

  key_rx_pkg::pow_t sample_pow;
  key_rx_pkg::pow_t thres_pow;
  logic [15:0] run_next;
  logic accepted;
  logic above;

  // i squared plus q squared with both components signed.
  function automatic key_rx_pkg::pow_t power_of(key_rx_pkg::sample_t s);
    logic signed [2*key_rx_pkg::sample_width-1:0] i_sq;
    logic signed [2*key_rx_pkg::sample_width-1:0] q_sq;
    i_sq = $signed(s.i) * $signed(s.i);
    q_sq = $signed(s.q) * $signed(s.q);
    return key_rx_pkg::pow_t'(i_sq) + key_rx_pkg::pow_t'(q_sq);
  endfunction

  always_comb begin
    sample_pow = power_of(in_tdata);
    thres_pow  = power_of(noise_thres);
  end

  assign accepted = in_tvalid && in_tready;
  assign above    = sample_pow > thres_pow; // equal power does not count as high.
  assign run_next = det_event.nrx_after_peak + 16'd1;

  // run length and run power.
  // A low sample or a frame end restarts the run from zero,
  // and the detector is held cleared while the controller is not writing.
  always_ff @(posedge clk) begin
    if (reset || clear || !enable) begin
      det_event <= '0;
    end else begin
      det_event.peak <= 1'b0;
      if (accepted) begin
        if (above && !in_tlast) begin
          det_event.nrx_after_peak <= run_next;
          det_event.pow            <= det_event.pow + sample_pow;
          det_event.peak           <= run_next == NRX_TRIG; // fires once per run.
        end else begin
          det_event.nrx_after_peak <= '0;
          det_event.pow            <= '0;
        end
      end
    end
  end

  // the controller reacts to a single strobe; a second one would start a second read.
  peak_single_cycle: assert property (
    @(posedge clk) disable iff (reset)
    det_event.peak |=> !det_event.peak
  ) else $error("peak strobe held for more than one cycle");

endmodule

`default_nettype wire

// ==== logic/key_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module key_mem #(
  parameter int ADDR_WIDTH = 10
) (
  input  wire logic                  clk,
  input  wire logic                  write_enable,
  input  wire logic [ADDR_WIDTH-1:0] write_addr,
  input  wire key_rx_pkg::sample_t   write_data,
  input  wire logic                  read_enable,
  input  wire logic [ADDR_WIDTH-1:0] read_addr,
  output key_rx_pkg::sample_t        read_data
);

  key_rx_pkg::sample_t mem [2**ADDR_WIDTH];

  always_ff @(posedge clk) begin
    if (write_enable) begin
      mem[write_addr] <= write_data;
    end
  end

  // output register keeps its word between reads.
  always_ff @(posedge clk) begin
    if (read_enable) begin
      read_data <= mem[read_addr];
    end
  end

  // the key start lies NFFT plus a run behind the write pointer, so the two never meet.
  no_read_write_collision: assert property (
    @(posedge clk)
    !(write_enable && read_enable && write_addr == read_addr)
  ) else $error("read and write to the same buffer address in one cycle");

endmodule

`default_nettype wire

// ==== logic/capture_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module capture_ctrl #(
  parameter int NFFT       = 512,
  parameter int NCP        = 128,
  parameter int ADDR_WIDTH = 10
) (
  input  wire logic                   clk,
  input  wire logic                   reset,
  input  wire logic                   clear,
  input  wire logic                   in_tvalid,
  input  wire logic                   in_tready,
  input  wire key_rx_pkg::sample_t    in_tdata,
  input  wire key_rx_pkg::det_event_t det_event,
  input  wire key_rx_pkg::sample_t    read_data,
  input  wire logic                   out_tready,
  output logic                        detect_enable,
  output logic                        write_enable,
  output logic [ADDR_WIDTH-1:0]       write_addr,
  output key_rx_pkg::sample_t         write_data,
  output logic                        read_enable,
  output logic [ADDR_WIDTH-1:0]       read_addr,
  output logic                        out_tvalid,
  output logic                        out_tlast,
  output key_rx_pkg::sample_t         out_tdata,
  output key_rx_pkg::pow_t            key_pow
);

  localparam int cnt_width  = $clog2(NFFT + 1);
  localparam int idle_len   = NFFT + NCP;
  localparam int idle_width = $clog2(idle_len + 1);

  key_rx_pkg::ctrl_state_e state;
  key_rx_pkg::sample_t skid_data;
  logic [ADDR_WIDTH-1:0] wr_ptr;
  logic [ADDR_WIDTH-1:0] rd_ptr;
  logic [ADDR_WIDTH-1:0] key_start;
  logic [cnt_width-1:0] rd_count;
  logic [cnt_width-1:0] tx_count;
  logic [idle_width-1:0] idle_count;
  logic [1:0] in_flight;
  logic accepted;
  logic start;
  logic more_reads;
  logic rd_pend;
  logic skid_valid;
  logic xfer;
  logic out_free;
  logic load_from_skid;
  logic load_from_mem;
  logic load_skid;

  assign accepted      = in_tvalid && in_tready;
  assign detect_enable = state == key_rx_pkg::st_write;
  assign write_enable  = detect_enable && accepted;
  assign write_addr    = wr_ptr;
  assign write_data    = in_tdata;

  // wr_ptr is one past the trigger sample here, so stepping back the run length
  // lands on the first run sample, and NFFT more gives the key start.
  assign start     = detect_enable && det_event.peak;
  assign key_start = wr_ptr - ADDR_WIDTH'(det_event.nrx_after_peak) - ADDR_WIDTH'(NFFT);

  assign xfer     = out_tvalid && out_tready;
  assign out_free = !out_tvalid || xfer;

  // words held after this edge, counting the one now leaving the buffer.
  assign in_flight = {1'b0, out_tvalid} + {1'b0, skid_valid} + {1'b0, rd_pend} - {1'b0, xfer};

  assign more_reads  = state == key_rx_pkg::st_read && rd_count != NFFT;
  assign read_enable = start || (more_reads && in_flight <= 2'd1);
  assign read_addr   = start ? key_start : rd_ptr;

  assign load_from_skid = out_free && skid_valid;
  assign load_from_mem  = out_free && !skid_valid && rd_pend;
  assign load_skid      = rd_pend && (out_free ? skid_valid : !skid_valid);

  assign out_tlast = out_tvalid && tx_count == NFFT - 1;

  always_ff @(posedge clk) begin
    if (reset || clear) begin
      state      <= key_rx_pkg::st_init;
      out_tvalid <= 1'b0;
      skid_valid <= 1'b0;
      rd_pend    <= 1'b0;
      rd_count   <= '0;
      tx_count   <= '0;
      idle_count <= '0;
      if (reset) begin
        wr_ptr <= '0; // buffer contents survive a clear, so the pointer does too.
        rd_ptr <= '0;
      end
    end else begin
      rd_pend <= read_enable;
      if (out_free) begin
        out_tvalid <= skid_valid || rd_pend;
        skid_valid <= skid_valid && rd_pend;
      end else begin
        skid_valid <= skid_valid || rd_pend;
      end
      if (write_enable) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (xfer) begin
        tx_count <= out_tlast ? '0 : tx_count + 1'b1;
      end

      case (state)
        key_rx_pkg::st_init: begin
          idle_count <= '0;
          state      <= key_rx_pkg::st_write;
        end
        key_rx_pkg::st_write: begin
          if (start) begin
            rd_ptr   <= key_start + 1'b1;
            rd_count <= cnt_width'(1);
            state    <= key_rx_pkg::st_read;
          end
        end
        key_rx_pkg::st_read: begin
          if (read_enable) begin
            rd_ptr   <= rd_ptr + 1'b1;
            rd_count <= rd_count + 1'b1;
          end
          if (xfer && out_tlast) begin
            state <= key_rx_pkg::st_wait;
          end
        end
        key_rx_pkg::st_wait: begin
          if (accepted) begin // only samples seen in this state count.
            if (idle_count == idle_len - 1) begin
              state <= key_rx_pkg::st_init;
            end else begin
              idle_count <= idle_count + 1'b1;
            end
          end
        end
        default: state <= key_rx_pkg::st_init;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (load_from_skid) begin
      out_tdata <= skid_data;
    end else if (load_from_mem) begin
      out_tdata <= read_data;
    end
    if (load_skid) begin
      skid_data <= read_data;
    end
    if (start) begin
      key_pow <= det_event.pow;
    end
  end

  out_valid_held: assert property (
    @(posedge clk) disable iff (reset)
    out_tvalid && !out_tready && !clear |=> out_tvalid
  ) else $error("out_tvalid dropped without a transfer");

  out_data_held: assert property (
    @(posedge clk) disable iff (reset)
    out_tvalid && !out_tready && !clear |=> $stable(out_tdata)
  ) else $error("out_tdata changed while waiting for out_tready");

endmodule

`default_nettype wire

// ==== logic/key_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module key_rx #(
  parameter int NFFT       = 512,
  parameter int NCP        = 128,
  parameter int ADDR_WIDTH = 10,
  parameter int NRX_TRIG   = 64
) (
  input  wire logic                clk,
  input  wire logic                reset,
  input  wire logic                clear,
  input  wire logic                in_tvalid,
  input  wire logic                in_tlast,
  input  wire key_rx_pkg::sample_t in_tdata,
  input  wire key_rx_pkg::sample_t noise_thres,
  input  wire logic                out_tready,
  output logic                     in_tready,
  output logic                     out_tvalid,
  output logic                     out_tlast,
  output key_rx_pkg::sample_t      out_tdata,
  output key_rx_pkg::pow_t         key_pow
);

  key_rx_pkg::det_event_t det_event;
  key_rx_pkg::sample_t write_data;
  key_rx_pkg::sample_t read_data;
  logic [ADDR_WIDTH-1:0] write_addr;
  logic [ADDR_WIDTH-1:0] read_addr;
  logic detect_enable;
  logic write_enable;
  logic read_enable;

  // the receiver never stalls the input once out of reset.
  assign in_tready = !reset;

  energy_detect #(
    .NRX_TRIG(NRX_TRIG)
  ) energy_detect_i (
    .clk(clk),
    .reset(reset),
    .clear(clear),
    .enable(detect_enable),
    .in_tvalid(in_tvalid),
    .in_tready(in_tready),
    .in_tlast(in_tlast),
    .in_tdata(in_tdata),
    .noise_thres(noise_thres),
    .det_event(det_event)
  );

  key_mem #(
    .ADDR_WIDTH(ADDR_WIDTH)
  ) key_mem_i (
    .clk(clk),
    .write_enable(write_enable),
    .write_addr(write_addr),
    .write_data(write_data),
    .read_enable(read_enable),
    .read_addr(read_addr),
    .read_data(read_data)
  );

  capture_ctrl #(
    .NFFT(NFFT),
    .NCP(NCP),
    .ADDR_WIDTH(ADDR_WIDTH)
  ) capture_ctrl_i (
    .clk(clk),
    .reset(reset),
    .clear(clear),
    .in_tvalid(in_tvalid),
    .in_tready(in_tready),
    .in_tdata(in_tdata),
    .det_event(det_event),
    .read_data(read_data),
    .out_tready(out_tready),
    .detect_enable(detect_enable),
    .write_enable(write_enable),
    .write_addr(write_addr),
    .write_data(write_data),
    .read_enable(read_enable),
    .read_addr(read_addr),
    .out_tvalid(out_tvalid),
    .out_tlast(out_tlast),
    .out_tdata(out_tdata),
    .key_pow(key_pow)
  );

endmodule

`default_nettype wire

// ==== sim/key_rx_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module key_rx_tb;

  localparam int nfft       = 16;
  localparam int ncp        = 4;
  localparam int addr_width = 6;
  localparam int nrx_trig   = 4;

  logic clk = 1'b0;
  logic reset;
  logic clear;
  logic in_tvalid;
  logic in_tlast;
  logic out_tready;
  logic in_tready;
  logic out_tvalid;
  logic out_tlast;
  key_rx_pkg::sample_t in_tdata;
  key_rx_pkg::sample_t noise_thres;
  key_rx_pkg::sample_t out_tdata;
  key_rx_pkg::pow_t key_pow;

  // frames as read from the data file.
  int frame_id[$];
  int frame_rand[$];
  int frame_first[$];
  int frame_nsamp[$];
  int frame_clear[$];
  int frame_keyfirst[$];
  int frame_nkey[$];
  key_rx_pkg::sample_t frame_thres[$];
  key_rx_pkg::sample_t samp_q[$];
  logic [31:0] keyw_q[$];

  key_rx_pkg::sample_t hist[$];      // every sample the receiver has stored so far.
  key_rx_pkg::sample_t model_key_q[$];
  longint model_pow;
  int idle_left = 0;                 // samples the receiver will skip before storing again.

  key_rx_pkg::sample_t got_q[$];
  logic got_last[$];
  key_rx_pkg::sample_t prev_data;
  logic prev_wait = 1'b0;

  int errors = 0;
  int passed = 0;
  int failed = 0;
  int rand_ready = 0;
  bit parsed = 1'b0;

  key_rx #(
    .NFFT(nfft),
    .NCP(ncp),
    .ADDR_WIDTH(addr_width),
    .NRX_TRIG(nrx_trig)
  ) key_rx_i (
    .clk(clk),
    .reset(reset),
    .clear(clear),
    .in_tvalid(in_tvalid),
    .in_tlast(in_tlast),
    .in_tdata(in_tdata),
    .noise_thres(noise_thres),
    .out_tready(out_tready),
    .in_tready(in_tready),
    .out_tvalid(out_tvalid),
    .out_tlast(out_tlast),
    .out_tdata(out_tdata),
    .key_pow(key_pow)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    if (rand_ready != 0) begin
      out_tready <= 1'($urandom % 2);
    end else begin
      out_tready <= 1'b1;
    end
  end

  // output monitor that samples the values from before the edge.
  always @(posedge clk) begin
    if (prev_wait) begin
      assert (out_tvalid && out_tdata == prev_data) else begin
        $display("Fail %0t: output word changed or dropped while waiting", $time);
        errors++;
      end
    end
    if (out_tvalid && out_tready) begin
      got_q.push_back(out_tdata);
      got_last.push_back(out_tlast);
    end
    prev_wait = out_tvalid && !out_tready && !clear && !reset;
    prev_data = out_tdata;
  end

  function automatic longint sample_power(key_rx_pkg::sample_t s);
    longint i_val;
    longint q_val;
    i_val = $signed(s.i);
    q_val = $signed(s.q);
    return i_val * i_val + q_val * q_val;
  endfunction

  task automatic read_stimulus;
    int fd;
    int code;
    int nf;
    int a;
    int b;
    int c;
    int d;
    int n;
    int k;
    string tok;
    string line;
    logic [31:0] w;
    key_rx_pkg::sample_t s;
    nf = -1;
    fd = $fopen("sim/key_rx_input.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file sim/key_rx_input.txt");
      errors++;
    end else begin
      while ($fscanf(fd, "%s", tok) == 1) begin
        case (tok)
          "#": code = $fgets(line, fd);
          "frame": begin
            code = $fscanf(fd, "%d %d", a, b);
            nf = frame_id.size();
            frame_id.push_back(a);
            frame_rand.push_back(b);
            frame_first.push_back(samp_q.size());
            frame_nsamp.push_back(0);
            frame_clear.push_back(0);
            frame_keyfirst.push_back(keyw_q.size());
            frame_nkey.push_back(0);
            frame_thres.push_back('0);
          end
          "thres": begin
            code = $fscanf(fd, "%d %d", a, b);
            s.i = a[15:0];
            s.q = b[15:0];
            frame_thres[nf] = s;
          end
          "ramp", "s": begin
            if (tok == "s") begin
              code = $fscanf(fd, "%d %d", a, b);
              n = 1;
              c = 0;
              d = 0;
            end else begin
              code = $fscanf(fd, "%d %d %d %d %d", n, a, b, c, d);
            end
            for (k = 0; k < n; k++) begin
              s.i = 16'(a + k * c);
              s.q = 16'(b + k * d);
              samp_q.push_back(s);
            end
            frame_nsamp[nf] += n;
          end
          "clear": frame_clear[nf] = 1;
          "key": begin
            code = $fscanf(fd, "%d", n);
            for (k = 0; k < n; k++) begin
              code = $fscanf(fd, "%h", w);
              keyw_q.push_back(w);
            end
            frame_nkey[nf] = n;
          end
          "end": ;
          default: begin
            $display("unknown entry %s in the stimulus file", tok);
            errors++;
          end
        endcase
      end
      $fclose(fd);
    end
  endtask

  // expected key from the detection rule while tracking what the receiver stores.
  task automatic model_frame(input int f);
    key_rx_pkg::sample_t s;
    longint thres;
    longint run_pow;
    int run;
    int run_start;
    int i;
    int j;
    model_key_q.delete();
    model_pow = 0;
    run = 0;
    run_pow = 0;
    run_start = 0;
    thres = sample_power(frame_thres[f]);
    for (i = 0; i < frame_nsamp[f]; i++) begin
      s = samp_q[frame_first[f] + i];
      if (idle_left > 0) begin
        idle_left--;
      end else if (model_key_q.size() == 0) begin
        hist.push_back(s);
        if (sample_power(s) > thres) begin
          if (run == 0) begin
            run_start = hist.size() - 1;
          end
          run++;
          run_pow += sample_power(s);
          if (run == nrx_trig) begin
            for (j = 0; j < nfft; j++) begin
              model_key_q.push_back(hist[run_start - nfft + j]);
            end
            model_pow = run_pow;
          end
        end else begin
          run = 0;
          run_pow = 0;
        end
      end
    end
    if (model_key_q.size() != 0) begin
      idle_left = frame_clear[f] ? 0 : nfft + ncp + 1; // wait period plus the init cycle.
    end
  endtask

  task automatic check_words(input int count);
    int k;
    for (k = 0; k < count; k++) begin
      assert (got_q[k] == model_key_q[k]) else begin
        $display("Fail %0t: key word %0d is %h, expected %h", $time, k, got_q[k],
                 model_key_q[k]);
        errors++;
      end
      assert (got_last[k] == (k == nfft - 1)) else begin
        $display("Fail %0t: out_tlast wrong on key word %0d", $time, k);
        errors++;
      end
    end
  endtask

  task automatic run_frame(input int f);
    int errors_before;
    int k;
    errors_before = errors;
    rand_ready <= frame_rand[f];
    model_frame(f);
    assert (frame_nkey[f] == model_key_q.size()) else begin
      $display("Fail %0t: data file lists %0d key words, model gives %0d", $time,
               frame_nkey[f], model_key_q.size());
      errors++;
    end
    for (k = 0; k < frame_nkey[f] && k < model_key_q.size(); k++) begin
      assert (keyw_q[frame_keyfirst[f] + k] == model_key_q[k]) else begin
        $display("Fail %0t: data file key word %0d differs from model", $time, k);
        errors++;
      end
    end
    got_q.delete();
    got_last.delete();
    @(posedge clk);
    noise_thres <= frame_thres[f];
    for (k = 0; k < frame_nsamp[f]; k++) begin
      @(posedge clk);
      in_tvalid <= 1'b1;
      in_tdata  <= samp_q[frame_first[f] + k];
    end
    @(posedge clk);
    in_tvalid <= 1'b0;
    if (model_key_q.size() == 0) begin
      repeat (40) @(posedge clk);
      assert (got_q.size() == 0) else begin
        $display("Fail %0t: key output without a trigger run", $time);
        errors++;
      end
    end else if (frame_clear[f] != 0) begin
      while (got_q.size() < 5) @(posedge clk);
      clear <= 1'b1;
      @(posedge clk);
      clear <= 1'b0;
      repeat (2) @(posedge clk);
      assert (!out_tvalid) else begin
        $display("Fail %0t: out_tvalid still high after clear", $time);
        errors++;
      end
      check_words(got_q.size() < nfft ? got_q.size() : nfft);
    end else begin
      while (got_q.size() < nfft) @(posedge clk);
      repeat (4) @(posedge clk); // any extra word would show up here.
      assert (got_q.size() == nfft) else begin
        $display("Fail %0t: %0d key words instead of %0d", $time, got_q.size(), nfft);
        errors++;
      end
      check_words(nfft);
    end
    if (model_key_q.size() != 0) begin
      assert (longint'(key_pow) == model_pow) else begin
        $display("Fail %0t: key_pow %0d, expected %0d", $time, key_pow, model_pow);
        errors++;
      end
    end
    if (errors == errors_before) begin
      passed++;
      $display("frame %0d passed", frame_id[f]);
    end else begin
      failed++;
      $display("frame %0d failed", frame_id[f]);
    end
  endtask

  initial begin
    int seed;
    int f;
    reset = 1'b1;
    clear = 1'b0;
    in_tvalid = 1'b0;
    in_tlast = 1'b0;
    in_tdata = '0;
    noise_thres = '0;
    out_tready = 1'b0;
    seed = $urandom(25);
    read_stimulus();
    parsed = 1'b1;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    repeat (4) @(posedge clk);
    assert (!out_tvalid && in_tready) else begin
      $display("Fail %0t: wrong handshake levels after reset", $time);
      errors++;
    end
    for (f = 0; f < frame_id.size(); f++) begin
      run_frame(f);
    end
    $display("tests passed: %0d, tests failed: %0d, errors: %0d", passed, failed, errors);
    if (errors == 0 && failed == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin
    longint limit;
    wait (parsed);
    limit = 4 * samp_q.size() * 20 + 2000;
    #(limit);
    $display("the run timed out before all frames were done");
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
logic/key_rx_pkg.sv
logic/energy_detect.sv
logic/key_mem.sv
logic/capture_ctrl.sv
logic/key_rx.sv
sim/key_rx_tb.sv

// ==== sim/key_rx_input.txt ====
# frame <id> <ready: 0 held high, 1 random>, thres <i> <q>, s <i> <q>,
# ramp <count> <i> <q> <i step> <q step>, clear, key <count> then hex words {i,q}, end
frame 1 0
thres 100 0
ramp 24 1 2 1 1
key 0
end
frame 2 0
thres 100 0
ramp 16 30 1 1 1
s 200 0
s 0 200
s 150 150
s 120 90
key 16
001e0001 001f0002 00200003 00210004 00220005 00230006 00240007 00250008
00260009 0027000a 0028000b 0029000c 002a000d 002b000e 002c000f 002d0010
end
frame 3 1
thres 100 0
ramp 21 5 5 0 0
ramp 16 30 1 1 1
s 200 0
s 0 200
s 150 150
s 120 90
key 16
001e0001 001f0002 00200003 00210004 00220005 00230006 00240007 00250008
00260009 0027000a 0028000b 0029000c 002a000d 002b000e 002c000f 002d0010
end
frame 4 0
thres 100 0
ramp 21 5 5 0 0
ramp 16 50 3 1 1
s 200 0
s 0 200
s 150 150
s 7 7
s 60 80
s 80 60
s 100 1
s 200 0
s 0 200
s 150 150
key 16
00380009 0039000a 003a000b 003b000c 003c000d 003d000e 003e000f 003f0010
00400011 00410012 00c80000 000000c8 00960096 00070007 003c0050 0050003c
end
frame 5 0
thres 100 0
ramp 8 5 5 0 0
ramp 6 200 0 0 0
ramp 7 5 5 0 0
ramp 16 10 40 1 1
s 0 200
s 200 0
s 0 150
s 150 0
key 16
000a0028 000b0029 000c002a 000d002b 000e002c 000f002d 0010002e 0011002f
00120030 00130031 00140032 00150033 00160034 00170035 00180036 00190037
end
frame 6 0
thres 100 0
ramp 21 5 5 0 0
ramp 16 70 10 1 1
s 200 0
s 0 200
s 150 150
s 120 90
clear
key 16
0046000a 0047000b 0048000c 0049000d 004a000e 004b000f 004c0010 004d0011
004e0012 004f0013 00500014 00510015 00520016 00530017 00540018 00550019
end
frame 7 1
thres 100 0
ramp 16 20 60 1 1
s 200 0
s 0 200
s 150 150
s 100 1
key 16
0014003c 0015003d 0016003e 0017003f 00180040 00190041 001a0042 001b0043
001c0044 001d0045 001e0046 001f0047 00200048 00210049 0022004a 0023004b
end
